// File: build.f
tone_pkg.sv
phase_sequencer.sv
quarter_wave_lut.sv
iq_packer.sv
chirp_tx_top.sv
tb_chirp_tx.sv

// File: chirp_tx_top.sv
`default_nettype none

module chirp_tx_top (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       restart,
  output wire                       out_tvalid,
  output wire tone_pkg::iq_sample_t out_tdata,
  output wire                       sync_ready,
  input  wire                       out_tready
);

  tone_pkg::seq_word_t seq;
  tone_pkg::sample_t   sin_sample;
  tone_pkg::sample_t   cos_sample;
  logic                advance;  // pipeline enable from the packer

  phase_sequencer phase_sequencer_inst (
    .clk     (clk),
    .rst     (rst),
    .restart (restart),
    .advance (advance),
    .seq     (seq)
  );

  // sine path
  quarter_wave_lut #(
    .QUADRANT_OFFSET (0)
  ) sin_lut_inst (
    .clk     (clk),
    .rst     (rst),
    .advance (advance),
    .phase   (seq.phase),
    .sample  (sin_sample)
  );

  // cosine path, a quarter turn ahead
  quarter_wave_lut #(
    .QUADRANT_OFFSET (1)
  ) cos_lut_inst (
    .clk     (clk),
    .rst     (rst),
    .advance (advance),
    .phase   (seq.phase),
    .sample  (cos_sample)
  );

  iq_packer iq_packer_inst (
    .clk        (clk),
    .rst        (rst),
    .seq        (seq),
    .sin_sample (sin_sample),
    .cos_sample (cos_sample),
    .out_tready (out_tready),
    .advance    (advance),
    .out_tvalid (out_tvalid),
    .out_tdata  (out_tdata),
    .sync_ready (sync_ready)
  );

endmodule

`default_nettype wire

// File: iq_packer.sv
`default_nettype none

module iq_packer (
  input  wire                      clk,
  input  wire                      rst,
  input  wire tone_pkg::seq_word_t seq,
  input  wire tone_pkg::sample_t   sin_sample,
  input  wire tone_pkg::sample_t   cos_sample,
  input  wire                      out_tready,
  output logic                     advance,
  output logic                     out_tvalid,
  output tone_pkg::iq_sample_t     out_tdata,
  output logic                     sync_ready
);

  localparam int LAST = tone_pkg::LUT_LATENCY - 1;

  logic                seq_valid;  // seq holds a real sample
  logic [LAST:0]       dl_valid;
  tone_pkg::seq_word_t dl_word [tone_pkg::LUT_LATENCY];

  // whole pipeline steps when the output slot is free or being taken
  assign advance = !out_tvalid || out_tready;

  always_ff @(posedge clk) begin
    if (rst) begin
      seq_valid  <= 1'b0;
      dl_valid   <= '0;
      out_tvalid <= 1'b0;
      sync_ready <= 1'b1;  // sync counter starts at all ones
    end else if (advance) begin
      seq_valid   <= 1'b1;
      dl_valid[0] <= seq_valid;
      for (int i = 1; i <= LAST; i++) begin
        dl_valid[i] <= dl_valid[i-1];
      end
      out_tvalid <= dl_valid[LAST];
      if (dl_valid[LAST]) begin
        sync_ready <= dl_word[LAST].sync;
      end
    end
  end

  // markers ride alongside the lookups
  always_ff @(posedge clk) begin
    if (advance) begin
      dl_word[0] <= seq;
      for (int i = 1; i <= LAST; i++) begin
        dl_word[i] <= dl_word[i-1];
      end
      out_tdata.sin   <= sin_sample;
      out_tdata.cos   <= cos_sample;
      out_tdata.phase <= dl_word[LAST].phase;
      out_tdata.tlast <= dl_word[LAST].symbol_last;
      out_tdata.sync  <= dl_word[LAST].sync;
    end
  end

  // a stalled beat is held until it is taken
  stall_holds_beat: assert property (
    @(posedge clk) disable iff (rst)
    out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata)
  );

endmodule

`default_nettype wire

// File: phase_sequencer.sv
`default_nettype none

module phase_sequencer (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 restart,
  input  wire                 advance,
  output tone_pkg::seq_word_t seq
);

  tone_pkg::phase_t    phase;
  tone_pkg::phase_t    phase_inc;
  tone_pkg::phase_t    start_phase;  // first phase of the next symbol
  tone_pkg::phase_t    sample_cnt;   // 1..NSIG within a symbol
  tone_pkg::nsymb_t    symb_cnt;     // 1..NSYMB within a frame
  tone_pkg::sync_cnt_t sync_cnt;
  logic                reload;       // next advance starts frame 1
  logic                reload_now;
  logic                symbol_end;
  logic                frame_end;

  assign symbol_end = (sample_cnt == tone_pkg::NSIG);
  assign frame_end  = symbol_end && (symb_cnt == tone_pkg::NSYMB);
  assign reload_now = reload || restart;

  assign seq.phase       = phase;
  assign seq.symbol_last = symbol_end;
  assign seq.sync        = &sync_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      phase       <= tone_pkg::START_PH;
      phase_inc   <= tone_pkg::START_PH_INC;
      start_phase <= tone_pkg::START_PH;
      sample_cnt  <= tone_pkg::NSIG;   // parked on the last sample
      symb_cnt    <= tone_pkg::NSYMB;  // of the last symbol
      sync_cnt    <= '1;
      reload      <= 1'b1;
    end else begin
      if (restart) begin
        reload <= 1'b1;  // word on display still goes out
      end
      if (advance) begin
        reload <= 1'b0;
        if (reload_now || frame_end) begin
          phase       <= tone_pkg::START_PH;
          phase_inc   <= tone_pkg::START_PH_INC;
          start_phase <= tone_pkg::START_PH - tone_pkg::NPH_SHIFT;
          sample_cnt  <= tone_pkg::phase_t'(1);
          symb_cnt    <= tone_pkg::nsymb_t'(1);
          if (reload_now) begin
            sync_cnt <= '1;  // frame 1 is a sync frame
          end else begin
            sync_cnt <= sync_cnt + tone_pkg::sync_cnt_t'(1);
          end
        end else if (symbol_end) begin
          phase       <= start_phase;
          phase_inc   <= phase_inc + tone_pkg::DPH_INC;  // steeper chirp
          start_phase <= start_phase - tone_pkg::NPH_SHIFT;
          sample_cnt  <= tone_pkg::phase_t'(1);
          symb_cnt    <= symb_cnt + tone_pkg::nsymb_t'(1);
        end else begin
          phase      <= phase + phase_inc;
          sample_cnt <= sample_cnt + tone_pkg::phase_t'(1);
        end
      end
    end
  end

  // counters wrap at their end values and never run past them
  sample_cnt_in_range: assert property (
    @(posedge clk) disable iff (rst)
    sample_cnt <= tone_pkg::NSIG
  );

  symb_cnt_in_range: assert property (
    @(posedge clk) disable iff (rst)
    symb_cnt <= tone_pkg::NSYMB
  );

endmodule

`default_nettype wire

// File: quarter_wave_lut.sv
`default_nettype none

module quarter_wave_lut #(
  parameter int QUADRANT_OFFSET = 0  // 1 turns sine into cosine
) (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   advance,
  input  wire tone_pkg::phase_t phase,
  output tone_pkg::sample_t     sample
);

  localparam int  LUT_DEPTH = 1 << tone_pkg::LUT_ADDR_W;
  localparam int  IDX_LSB   = tone_pkg::PHASE_W - 2 - tone_pkg::LUT_ADDR_W;
  localparam real HALF_PI   = 1.5707963267948966;

  tone_pkg::sample_t               quarter_rom [LUT_DEPTH];
  logic [1:0]                      quadrant;
  logic [tone_pkg::LUT_ADDR_W-1:0] idx;
  logic [tone_pkg::LUT_ADDR_W-1:0] rom_addr;
  logic                            rom_peak;  // odd quadrant at idx 0, sin = 1
  logic                            rom_neg;
  tone_pkg::sample_t               magnitude;

  // first quarter wave, rounded to nearest
  initial begin
    for (int i = 0; i < LUT_DEPTH; i++) begin
      quarter_rom[i] = tone_pkg::sample_t'($rtoi($floor(
        real'(tone_pkg::AMPL) * $sin(HALF_PI * real'(i) / real'(LUT_DEPTH)) + 0.5)));
    end
  end

  assign quadrant = phase[tone_pkg::PHASE_W-1 -: 2] + 2'(QUADRANT_OFFSET);
  assign idx      = phase[IDX_LSB +: tone_pkg::LUT_ADDR_W];

  // stage 1: fold into the first quadrant
  always_ff @(posedge clk) begin
    if (advance) begin
      rom_addr <= quadrant[0] ? -idx : idx;  // mirror in odd quadrants
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rom_peak <= 1'b0;
      rom_neg  <= 1'b0;
    end else if (advance) begin
      rom_peak <= quadrant[0] && (idx == '0);
      rom_neg  <= quadrant[1];  // second half wave
    end
  end

  // stage 2: table read and sign
  assign magnitude = rom_peak ? tone_pkg::AMPL : quarter_rom[rom_addr];

  always_ff @(posedge clk) begin
    if (rst) begin
      sample <= '0;
    end else if (advance) begin
      sample <= rom_neg ? -magnitude : magnitude;
    end
  end

  sample_in_range: assert property (
    @(posedge clk) disable iff (rst)
    (sample <= tone_pkg::AMPL) && (sample >= -tone_pkg::AMPL)
  );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# compile and run the chirp transmitter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f build.f --top-module tb_chirp_tx -o sim_chirp_tx

status=0
output=$(./obj_dir/sim_chirp_tx) || status=$?
echo "$output"

if echo "$output" | grep -qx "TEST PASSED"; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed (exit status $status)"
exit 1

// File: tb_chirp_tx.sv
`default_nettype none

module tb_chirp_tx;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          CLK_PERIOD_NS = 8;
  localparam int          RESET_CYCLES  = 3;
  localparam int unsigned RAND_SEED     = 32'h6880_3209;

  localparam int NSIG_I   = int'(tone_pkg::NSIG);
  localparam int NSYMB_I  = int'(tone_pkg::NSYMB);
  localparam int FRAME    = NSIG_I * NSYMB_I;  // samples per frame
  localparam int SYNC_MAX = (1 << tone_pkg::TX_SYNC_BITS) - 1;
  localparam int RESTART_AFTER = 21;  // lands in the middle of symbol 2

  localparam int TOTAL_BEATS = 2 * FRAME + 2 * FRAME + 17 * FRAME + 2 * FRAME
                               + RESTART_AFTER + tone_pkg::LUT_LATENCY + 2 + FRAME;
  localparam int WATCHDOG_NS = TOTAL_BEATS * 8 * CLK_PERIOD_NS;

  localparam real TWO_PI = 6.283185307179586;

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 restart;
  logic                 out_tready;
  logic                 out_tvalid;
  tone_pkg::iq_sample_t out_tdata;
  logic                 sync_ready;

  tone_pkg::phase_t ref_phases[$];  // phases seen with out_tready held high
  int unsigned      seed_discard;

  chirp_tx_top chirp_tx_top_inst (
    .clk        (clk),
    .rst        (rst),
    .restart    (restart),
    .out_tvalid (out_tvalid),
    .out_tdata  (out_tdata),
    .sync_ready (sync_ready),
    .out_tready (out_tready)
  );

  always #(CLK_PERIOD_NS / 2) clk = ~clk;

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0d ns: %s got %0h expected %0h", $time, name, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // n counts transfers since reset or restart
  function automatic tone_pkg::phase_t expected_phase(input int n);
    int symb;
    int k;
    symb = (n / NSIG_I) % NSYMB_I;
    k    = n % NSIG_I;
    return tone_pkg::phase_t'(int'(tone_pkg::START_PH) - symb * int'(tone_pkg::NPH_SHIFT)
           + k * (int'(tone_pkg::START_PH_INC) + symb * int'(tone_pkg::DPH_INC)));
  endfunction

  function automatic logic expected_tlast(input int n);
    return (n % NSIG_I) == NSIG_I - 1;
  endfunction

  // sync counter starts at all ones and steps once per frame
  function automatic logic expected_sync(input int n);
    int count;
    count = (SYNC_MAX + n / FRAME) % (SYNC_MAX + 1);
    return count == SYNC_MAX;
  endfunction

  function automatic real ideal_wave(input tone_pkg::phase_t ph, input bit cosine);
    real angle;
    angle = TWO_PI * real'(ph[tone_pkg::PHASE_W-1 -: 12]) / 4096.0;
    if (cosine) begin
      return real'(tone_pkg::AMPL) * $cos(angle);
    end
    return real'(tone_pkg::AMPL) * $sin(angle);
  endfunction

  task automatic apply_reset();
    @(negedge clk);
    rst        = 1'b1;
    restart    = 1'b0;
    out_tready = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    check_value("out_tvalid in reset", 64'(out_tvalid), 64'd0);
    rst = 1'b0;
  endtask

  // waits for one transfer, checking that a stalled beat holds
  task automatic next_beat(input bit random_ready, output tone_pkg::iq_sample_t beat,
                           output logic sync_lvl);
    tone_pkg::iq_sample_t held;
    bit                   stalled;
    bit                   got;
    stalled = 1'b0;
    got     = 1'b0;
    held    = '0;
    while (!got) begin
      @(negedge clk);
      restart = 1'b0;  // strobe lasts one cycle
      if (stalled) begin
        check_value("out_tvalid while stalled", 64'(out_tvalid), 64'd1);
        check_value("out_tdata while stalled", 64'(out_tdata), 64'(held));
      end
      out_tready = random_ready ? (($urandom() & 32'd1) != 0) : 1'b1;
      if (out_tvalid && out_tready) begin
        beat     = out_tdata;  // taken on the coming rising edge
        sync_lvl = sync_ready;
        got      = 1'b1;
      end
      stalled = out_tvalid && !out_tready;
      held    = out_tdata;
    end
  endtask

  task automatic check_sample(input string name, input tone_pkg::sample_t actual,
                              input real ideal);
    real err;
    bit  close;
    err   = real'(actual) - ideal;
    close = (err <= 2.0) && (err >= -2.0);
    check_value($sformatf("%s %0d within 2 LSB of %0.2f", name, actual, ideal),
                64'(close), 64'd1);
  endtask

  task automatic test_phase_sequence();
    tone_pkg::iq_sample_t beat;
    logic                 sync_lvl;
    apply_reset();
    ref_phases.delete();
    for (int n = 0; n < 2 * FRAME; n++) begin
      next_beat(1'b0, beat, sync_lvl);
      check_value($sformatf("out_tdata.phase #%0d", n), 64'(beat.phase),
                  64'(expected_phase(n)));
      ref_phases.push_back(beat.phase);
    end
  endtask

  task automatic test_sample_values();
    tone_pkg::iq_sample_t beat;
    logic                 sync_lvl;
    apply_reset();
    for (int n = 0; n < 2 * FRAME; n++) begin
      next_beat(1'b0, beat, sync_lvl);
      check_sample($sformatf("out_tdata.sin at %06h", beat.phase), beat.sin,
                   ideal_wave(beat.phase, 1'b0));
      check_sample($sformatf("out_tdata.cos at %06h", beat.phase), beat.cos,
                   ideal_wave(beat.phase, 1'b1));
    end
  endtask

  task automatic test_markers();
    tone_pkg::iq_sample_t beat;
    logic                 sync_lvl;
    apply_reset();
    for (int n = 0; n < 17 * FRAME; n++) begin  // frame 17 is the next sync frame
      next_beat(1'b0, beat, sync_lvl);
      check_value($sformatf("out_tdata.tlast #%0d", n), 64'(beat.tlast),
                  64'(expected_tlast(n)));
      check_value($sformatf("out_tdata.sync #%0d", n), 64'(beat.sync),
                  64'(expected_sync(n)));
      check_value($sformatf("sync_ready #%0d", n), 64'(sync_lvl), 64'(expected_sync(n)));
    end
  endtask

  task automatic test_back_pressure();
    tone_pkg::iq_sample_t beat;
    logic                 sync_lvl;
    apply_reset();
    for (int n = 0; n < 2 * FRAME; n++) begin
      next_beat(1'b1, beat, sync_lvl);
      check_value($sformatf("out_tdata.phase under back-pressure #%0d", n),
                  64'(beat.phase), 64'(ref_phases[n]));
    end
  endtask

  task automatic test_restart();
    tone_pkg::iq_sample_t beat;
    logic                 sync_lvl;
    int                   skipped;
    bit                   found;
    apply_reset();
    for (int n = 0; n < RESTART_AFTER; n++) begin
      next_beat(1'b0, beat, sync_lvl);
      check_value($sformatf("out_tdata.phase before restart #%0d", n), 64'(beat.phase),
                  64'(expected_phase(n)));
    end
    restart = 1'b1;  // seen at the next rising edge
    skipped = 0;
    found   = 1'b0;
    while (!found && skipped <= tone_pkg::LUT_LATENCY + 1) begin
      next_beat(1'b0, beat, sync_lvl);
      if (beat.phase == tone_pkg::START_PH) begin
        found = 1'b1;
      end else begin
        skipped++;
      end
    end
    if (!found) begin
      $display("restart did not start a new frame within %0d samples",
               tone_pkg::LUT_LATENCY + 1);
      $display("TEST FAILED");
      $fatal(1, "restart not seen");
    end
    // a whole fresh frame follows, sync frame included
    for (int n = 0; n < FRAME; n++) begin
      if (n > 0) begin
        next_beat(1'b0, beat, sync_lvl);
      end
      check_value($sformatf("out_tdata.phase after restart #%0d", n), 64'(beat.phase),
                  64'(expected_phase(n)));
      check_value($sformatf("out_tdata.tlast after restart #%0d", n), 64'(beat.tlast),
                  64'(expected_tlast(n)));
      check_value($sformatf("out_tdata.sync after restart #%0d", n), 64'(beat.sync),
                  64'(expected_sync(n)));
    end
  endtask

  initial begin
    rst          = 1'b1;
    restart      = 1'b0;
    out_tready   = 1'b0;
    seed_discard = $urandom(RAND_SEED);
    test_phase_sequence();
    test_sample_values();
    test_markers();
    test_back_pressure();
    test_restart();
    $display("TEST PASSED");
    $finish;
  end

  // bound on the whole run
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: tone_pkg.sv
`default_nettype none

package tone_pkg;

  // widths
  localparam int PHASE_W      = 24;
  localparam int SAMPLE_W     = 16;
  localparam int NSYMB_W      = 16;
  localparam int TX_SYNC_BITS = 4;
  localparam int LUT_ADDR_W   = 10;   // phase bits below the quadrant bits

  localparam int LUT_LATENCY  = 2;    // advances through one lookup

  typedef logic [PHASE_W-1:0]         phase_t;
  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic [NSYMB_W-1:0]         nsymb_t;
  typedef logic [TX_SYNC_BITS-1:0]    sync_cnt_t;

  // sequence constants
  localparam phase_t NSIG         = 24'd16;     // samples per symbol
  localparam nsymb_t NSYMB        = 16'd4;      // symbols per frame
  localparam phase_t START_PH     = 24'd0;
  localparam phase_t START_PH_INC = 24'd8192;
  localparam phase_t DPH_INC      = 24'd16384;  // increment growth per symbol
  localparam phase_t NPH_SHIFT    = 24'd4096;   // start phase step down per symbol

  localparam sample_t AMPL = 16'sd32767;

  // sequencer output, 26 bits
  typedef struct packed {
    phase_t phase;
    logic   symbol_last;
    logic   sync;
  } seq_word_t;

  // output stream sample, 58 bits
  typedef struct packed {
    sample_t sin;
    sample_t cos;
    phase_t  phase;
    logic    tlast;
    logic    sync;
  } iq_sample_t;

endpackage

`default_nettype wire
